/* rtl/line_cache_pkg.sv */
package line_cache_pkg;

  // Default geometry, overridden from the top level if needed
  localparam int DEF_ADDR_WIDTH  = 32;
  localparam int DEF_DATA_WIDTH  = 32;
  localparam int DEF_CLINE_WIDTH = 128;

  // Small on purpose so index conflicts are easy to hit
  localparam int DEF_NLINES      = 16;

  // Controller states
  typedef enum logic [1:0] {
    // Serving hits
    ST_IDLE,
    // Dirty victim offered to memory
    ST_WRITEBACK,
    // Burst read being requested
    ST_REFILL_REQ,
    // Refill words being collected
    ST_REFILL_DATA
  } cache_state_t;

endpackage

/* rtl/tag_store.sv */
`timescale 1ns/1ps

module tag_store
  import line_cache_pkg::*;
#(
  parameter int ADDR_WIDTH  = DEF_ADDR_WIDTH,
  parameter int CLINE_WIDTH = DEF_CLINE_WIDTH,
  parameter int NLINES      = DEF_NLINES,
  localparam int OFFSET_BITS = $clog2(CLINE_WIDTH / 8),
  localparam int INDEX_BITS  = $clog2(NLINES),
  localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS
)(
  input  logic                  clock,
  input  logic                  reset_n,

  input  logic [INDEX_BITS-1:0] index,
  input  logic [TAG_BITS-1:0]   tag,
  input  logic                  tag_we,
  input  logic                  new_dirty,

  output logic                  hit,
  output logic                  victim_valid,
  output logic                  victim_dirty,
  output logic [TAG_BITS-1:0]   victim_tag
);

  // Per-line state bits
  logic [NLINES-1:0] valid_q;
  logic [NLINES-1:0] dirty_q;

  logic [TAG_BITS-1:0] tag_q [NLINES];

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag_we) begin
      valid_q[index] <= 1'b1;
      dirty_q[index] <= new_dirty;
    end
  end

  // Tags are meaningless until the valid bit is set
  always_ff @(posedge clock) begin
    if (tag_we) begin
      tag_q[index] <= tag;
    end
  end

  // Lookup of the entry at the current index
  assign victim_valid = valid_q[index];
  assign victim_dirty = dirty_q[index];
  assign victim_tag   = tag_q[index];

  assign hit = victim_valid && (victim_tag == tag);

endmodule

/* rtl/line_store.sv */
`timescale 1ns/1ps

module line_store
  import line_cache_pkg::*;
#(
  parameter int CLINE_WIDTH = DEF_CLINE_WIDTH,
  parameter int NLINES      = DEF_NLINES,
  localparam int INDEX_BITS = $clog2(NLINES)
)(
  input  logic                   clock,

  input  logic [INDEX_BITS-1:0]  index,
  input  logic                   line_we,
  input  logic [CLINE_WIDTH-1:0] new_line,

  output logic [CLINE_WIDTH-1:0] stored_line
);

  // One full line per index
  logic [CLINE_WIDTH-1:0] lines_q [NLINES];

  // Whole-line write, either from the CPU or from a finished refill
  always_ff @(posedge clock) begin
    if (line_we) begin
      lines_q[index] <= new_line;
    end
  end

  // Read side feeds both the CPU response and the writeback data
  assign stored_line = lines_q[index];

endmodule

/* rtl/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller
  import line_cache_pkg::*;
#(
  parameter int ADDR_WIDTH  = DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int CLINE_WIDTH = DEF_CLINE_WIDTH,
  parameter int NLINES      = DEF_NLINES,
  localparam int NWORDS      = CLINE_WIDTH / DATA_WIDTH,
  localparam int OFFSET_BITS = $clog2(CLINE_WIDTH / 8),
  localparam int INDEX_BITS  = $clog2(NLINES),
  localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS,
  localparam int CNT_WIDTH   = (NWORDS > 1) ? $clog2(NWORDS) : 1
)(
  input  logic                   clock,
  input  logic                   reset_n,

  // CPU request, address already split by the top level
  input  logic                   cpu_rd,
  input  logic                   cpu_wr,
  input  logic [CLINE_WIDTH-1:0] cpu_wr_line,
  input  logic [INDEX_BITS-1:0]  index,
  input  logic [TAG_BITS-1:0]    tag,

  // Lookup results
  input  logic                   hit,
  input  logic                   victim_valid,
  input  logic                   victim_dirty,
  input  logic [TAG_BITS-1:0]    victim_tag,
  input  logic [CLINE_WIDTH-1:0] stored_line,

  // Store updates
  output logic                   tag_we,
  output logic                   new_dirty,
  output logic                   line_we,
  output logic [CLINE_WIDTH-1:0] new_line,

  // CPU response
  output logic                   cpu_waitrequest,
  output logic                   cpu_rd_valid,
  output logic [CLINE_WIDTH-1:0] cpu_rd_line,

  // Memory side
  output logic [ADDR_WIDTH-1:0]  mem_addr,
  output logic                   mem_wr,
  output logic [CLINE_WIDTH-1:0] mem_wr_data,
  output logic                   mem_rd,
  input  logic                   mem_waitrequest,
  input  logic [DATA_WIDTH-1:0]  mem_rd_data,
  input  logic                   mem_rd_valid
);

  cache_state_t state_q;
  cache_state_t state_d;

  logic                   req;
  logic                   dirty_victim;
  logic                   need_mem;
  logic                   accept_rd;
  logic                   accept_wr;
  logic                   wb_done;
  logic                   fill_last;
  logic [CNT_WIDTH-1:0]   word_cnt_q;
  logic [CLINE_WIDTH-1:0] fill_q;
  logic [CLINE_WIDTH-1:0] fill_line;
  logic                   rd_valid_q;
  logic [CLINE_WIDTH-1:0] rd_line_q;

  assign req          = cpu_rd | cpu_wr;
  // Valid line of another tag that memory has not seen yet
  assign dirty_victim = victim_valid & victim_dirty & ~hit;

  // Writes to clean or invalid lines allocate without memory
  assign need_mem = (cpu_rd & ~hit) | (cpu_wr & dirty_victim);

  assign cpu_waitrequest = req & ((state_q != ST_IDLE) | need_mem);
  assign accept_rd       = cpu_rd & ~cpu_waitrequest;
  assign accept_wr       = cpu_wr & ~cpu_waitrequest;

  assign wb_done   = (state_q == ST_WRITEBACK) & ~mem_waitrequest;
  assign fill_last = (state_q == ST_REFILL_DATA) & mem_rd_valid &
                     (word_cnt_q == CNT_WIDTH'(NWORDS - 1));

  // Words enter at the top, so the first one ends up least significant
  assign fill_line = {mem_rd_data, fill_q[CLINE_WIDTH-1:DATA_WIDTH]};

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req && need_mem) begin
          if (dirty_victim) begin
            state_d = ST_WRITEBACK;
          end else begin
            state_d = ST_REFILL_REQ;
          end
        end
      end
      ST_WRITEBACK: begin
        // A held write goes back to idle and then hits
        if (!mem_waitrequest) begin
          state_d = cpu_rd ? ST_REFILL_REQ : ST_IDLE;
        end
      end
      ST_REFILL_REQ: begin
        if (!mem_waitrequest) begin
          state_d = ST_REFILL_DATA;
        end
      end
      ST_REFILL_DATA: begin
        if (fill_last) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Store update selection
  always_comb begin
    tag_we    = 1'b0;
    new_dirty = 1'b0;
    line_we   = 1'b0;
    new_line  = cpu_wr_line;
    if (accept_wr) begin
      tag_we    = 1'b1;
      new_dirty = 1'b1;
      line_we   = 1'b1;
    end else if (wb_done) begin
      // Entry now clean under the requested tag, the data is replaced next
      tag_we = 1'b1;
    end else if (fill_last) begin
      tag_we   = 1'b1;
      line_we  = 1'b1;
      new_line = fill_line;
    end
  end

  // Refill word count
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      word_cnt_q <= '0;
    end else if (state_q != ST_REFILL_DATA) begin
      word_cnt_q <= '0;
    end else if (mem_rd_valid) begin
      word_cnt_q <= word_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == ST_REFILL_DATA && mem_rd_valid) begin
      fill_q <= fill_line;
    end
  end

  // One-cycle read response
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= accept_rd;
    end
  end

  always_ff @(posedge clock) begin
    if (accept_rd) begin
      rd_line_q <= stored_line;
    end
  end

  assign cpu_rd_valid = rd_valid_q;
  assign cpu_rd_line  = rd_line_q;

  // Victim address while writing back, requested address otherwise
  assign mem_addr = (state_q == ST_WRITEBACK) ?
                    {victim_tag, index, {OFFSET_BITS{1'b0}}} :
                    {tag, index, {OFFSET_BITS{1'b0}}};

  assign mem_wr_data = stored_line;
  assign mem_wr      = (state_q == ST_WRITEBACK);
  assign mem_rd      = (state_q == ST_REFILL_REQ);

endmodule

/* rtl/line_cache.sv */
`timescale 1ns/1ps

module line_cache
  import line_cache_pkg::*;
#(
  parameter int ADDR_WIDTH  = DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int CLINE_WIDTH = DEF_CLINE_WIDTH,
  parameter int NLINES      = DEF_NLINES
)(
  input  logic                   clock,
  input  logic                   reset_n,

  input  logic [ADDR_WIDTH-1:0]  cpu_addr,
  input  logic                   cpu_rd,
  input  logic                   cpu_wr,
  input  logic [CLINE_WIDTH-1:0] cpu_wr_line,
  output logic                   cpu_waitrequest,
  output logic                   cpu_rd_valid,
  output logic [CLINE_WIDTH-1:0] cpu_rd_line,

  output logic [ADDR_WIDTH-1:0]  mem_addr,
  output logic                   mem_wr,
  output logic [CLINE_WIDTH-1:0] mem_wr_data,
  output logic                   mem_rd,
  input  logic                   mem_waitrequest,
  input  logic [DATA_WIDTH-1:0]  mem_rd_data,
  input  logic                   mem_rd_valid
);

  localparam int OFFSET_BITS = $clog2(CLINE_WIDTH / 8);
  localparam int INDEX_BITS  = $clog2(NLINES);
  localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

  // Address split, offset bits select nothing since whole lines move
  logic [INDEX_BITS-1:0]  index;
  logic [TAG_BITS-1:0]    tag;

  logic                   hit;
  logic                   victim_valid;
  logic                   victim_dirty;
  logic [TAG_BITS-1:0]    victim_tag;
  logic [CLINE_WIDTH-1:0] stored_line;
  logic                   tag_we;
  logic                   new_dirty;
  logic                   line_we;
  logic [CLINE_WIDTH-1:0] new_line;

  assign index = cpu_addr[OFFSET_BITS +: INDEX_BITS];
  assign tag   = cpu_addr[ADDR_WIDTH-1 -: TAG_BITS];

  tag_store #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .CLINE_WIDTH (CLINE_WIDTH),
    .NLINES      (NLINES)
  ) u_tag_store (
    .clock        (clock),
    .reset_n      (reset_n),
    .index        (index),
    .tag          (tag),
    .tag_we       (tag_we),
    .new_dirty    (new_dirty),
    .hit          (hit),
    .victim_valid (victim_valid),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  line_store #(
    .CLINE_WIDTH (CLINE_WIDTH),
    .NLINES      (NLINES)
  ) u_line_store (
    .clock       (clock),
    .index       (index),
    .line_we     (line_we),
    .new_line    (new_line),
    .stored_line (stored_line)
  );

  cache_controller #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .CLINE_WIDTH (CLINE_WIDTH),
    .NLINES      (NLINES)
  ) u_cache_controller (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_wr_line     (cpu_wr_line),
    .index           (index),
    .tag             (tag),
    .hit             (hit),
    .victim_valid    (victim_valid),
    .victim_dirty    (victim_dirty),
    .victim_tag      (victim_tag),
    .stored_line     (stored_line),
    .tag_we          (tag_we),
    .new_dirty       (new_dirty),
    .line_we         (line_we),
    .new_line        (new_line),
    .cpu_waitrequest (cpu_waitrequest),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_line     (cpu_rd_line),
    .mem_addr        (mem_addr),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_rd          (mem_rd),
    .mem_waitrequest (mem_waitrequest),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid)
  );

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
)(
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // Released just after an edge, like the rest of the stimulus
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset_n = 1'b1;
  end

endmodule

/* tests/line_cache_props.sv */
`timescale 1ns/1ps

module line_cache_props
  import line_cache_pkg::*;
#(
  parameter int ADDR_WIDTH  = DEF_ADDR_WIDTH,
  parameter int CLINE_WIDTH = DEF_CLINE_WIDTH,
  parameter int NLINES      = DEF_NLINES,
  localparam int OFFSET_BITS = $clog2(CLINE_WIDTH / 8),
  localparam int INDEX_BITS  = $clog2(NLINES),
  localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS
)(
  input logic                   clock,
  input logic                   reset_n,
  input logic                   cpu_rd,
  input logic                   cpu_wr,
  input logic [CLINE_WIDTH-1:0] cpu_wr_line,
  input logic [INDEX_BITS-1:0]  index,
  input logic [TAG_BITS-1:0]    tag,
  input logic                   cpu_waitrequest,
  input logic                   mem_rd,
  input logic                   mem_wr,
  input logic                   mem_waitrequest
);

  int unsigned fail_count = 0;

  cpu_one_request: assert property (@(posedge clock) disable iff (!reset_n)
    !(cpu_rd && cpu_wr))
    else begin
      $error("cpu_rd and cpu_wr high together");
      fail_count++;
    end

  mem_one_request: assert property (@(posedge clock) disable iff (!reset_n)
    !(mem_rd && mem_wr))
    else begin
      $error("mem_rd and mem_wr high together");
      fail_count++;
    end

  // Requester holds everything while stalled
  cpu_held: assert property (@(posedge clock) disable iff (!reset_n)
    cpu_waitrequest |=> $stable(cpu_rd) && $stable(cpu_wr) && $stable(index) &&
                        $stable(tag) && $stable(cpu_wr_line))
    else begin
      $error("CPU request changed while cpu_waitrequest was high");
      fail_count++;
    end

  mem_rd_held: assert property (@(posedge clock) disable iff (!reset_n)
    (mem_rd && mem_waitrequest) |=> mem_rd)
    else begin
      $error("mem_rd dropped before memory accepted it");
      fail_count++;
    end

endmodule

bind cache_controller line_cache_props #(
  .ADDR_WIDTH  (ADDR_WIDTH),
  .CLINE_WIDTH (CLINE_WIDTH),
  .NLINES      (NLINES)
) u_line_cache_props (
  .clock           (clock),
  .reset_n         (reset_n),
  .cpu_rd          (cpu_rd),
  .cpu_wr          (cpu_wr),
  .cpu_wr_line     (cpu_wr_line),
  .index           (index),
  .tag             (tag),
  .cpu_waitrequest (cpu_waitrequest),
  .mem_rd          (mem_rd),
  .mem_wr          (mem_wr),
  .mem_waitrequest (mem_waitrequest)
);

/* tests/tb_line_cache.sv */
`timescale 1ns/1ps

module tb_line_cache
  import line_cache_pkg::*;
();

  localparam int ADDR_WIDTH  = DEF_ADDR_WIDTH;
  localparam int DATA_WIDTH  = DEF_DATA_WIDTH;
  localparam int CLINE_WIDTH = DEF_CLINE_WIDTH;
  localparam int NLINES      = DEF_NLINES;
  localparam int NWORDS      = CLINE_WIDTH / DATA_WIDTH;
  localparam int OFFSET_BITS = $clog2(CLINE_WIDTH / 8);
  localparam int INDEX_BITS  = $clog2(NLINES);

  localparam logic [31:0] LFSR_SEED = 32'hc2c3_cc5a;
  localparam int MAX_STALL  = 3;
  localparam int N_DIRECTED = 10;
  localparam int N_RANDOM   = 300;
  // Writeback, burst request and each word stalled as long as the model allows
  localparam int WORST_CYCLES = (MAX_STALL + 1) * (NWORDS + 2) + 6;
  localparam longint WATCHDOG_NS =
    longint'(N_DIRECTED + N_RANDOM) * WORST_CYCLES * 10 + 2000;

  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [CLINE_WIDTH-1:0] line_t;
  typedef logic [DATA_WIDTH-1:0]  word_t;

  localparam addr_t ADDR_A      = 32'h0000_1234;
  localparam addr_t ADDR_B      = 32'h0000_5630;
  localparam addr_t ADDR_C      = 32'h0000_2048;
  localparam addr_t ADDR_E      = 32'h0000_7744;
  localparam addr_t RANDOM_BASE = 32'h0010_0000;
  localparam line_t LINE_D      = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

  logic  clock;
  logic  reset_n;
  addr_t cpu_addr;
  logic  cpu_rd;
  logic  cpu_wr;
  line_t cpu_wr_line;
  logic  cpu_waitrequest;
  logic  cpu_rd_valid;
  line_t cpu_rd_line;
  addr_t mem_addr;
  logic  mem_wr;
  line_t mem_wr_data;
  logic  mem_rd;
  logic  mem_waitrequest;
  word_t mem_rd_data;
  logic  mem_rd_valid;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr_q = LFSR_SEED;

  // Memory contents and the testbench's own expectation, keyed by line address
  line_t mem_lines [addr_t];
  line_t ref_lines [addr_t];
  int    mem_wr_count = 0;
  int    mem_rd_count = 0;
  addr_t last_wb_addr;
  line_t last_wb_data;

  clock_gen u_clock_gen (
    .clock   (clock),
    .reset_n (reset_n)
  );

  line_cache #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .CLINE_WIDTH (CLINE_WIDTH),
    .NLINES      (NLINES)
  ) u_line_cache (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_wr_line     (cpu_wr_line),
    .cpu_waitrequest (cpu_waitrequest),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_line     (cpu_rd_line),
    .mem_addr        (mem_addr),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_rd          (mem_rd),
    .mem_waitrequest (mem_waitrequest),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid)
  );

  // Right-shifting Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end else begin
      return state >> 1;
    end
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return bits;
  endfunction

  // Content of a never-written line
  function automatic line_t rule_line(addr_t line_addr);
    line_t line;
    addr_t word_addr;
    for (int i = 0; i < NWORDS; i++) begin
      word_addr = line_addr + addr_t'(i * (DATA_WIDTH / 8));
      line[i*DATA_WIDTH +: DATA_WIDTH] = word_t'(word_addr ^ 32'h5a5a_0000);
    end
    return line;
  endfunction

  function automatic addr_t line_base(addr_t addr);
    return {addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  endfunction

  function automatic line_t expected_line(addr_t addr);
    if (ref_lines.exists(line_base(addr))) begin
      return ref_lines[line_base(addr)];
    end else begin
      return rule_line(line_base(addr));
    end
  endfunction

  task automatic check_line(input string name, input line_t got, input line_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Wrong number of %s: saw %0d, expected %0d", what, got, exp);
    end
  endtask

  task automatic check_traffic(input int rd0, input int wr0, input int reads, input int writes);
    check_count("memory reads", mem_rd_count - rd0, reads);
    check_count("memory writes", mem_wr_count - wr0, writes);
  endtask

  // Bursts with bounded random stalls, sampled mid-cycle
  initial begin : memory_model
    logic  stall;
    logic  gap;
    int    stall_run;
    int    gap_run;
    int    burst_word;
    int    burst_left;
    line_t burst_line;
    stall_run       = 0;
    gap_run         = 0;
    burst_word      = 0;
    burst_left      = 0;
    burst_line      = '0;
    mem_waitrequest = 1'b0;
    mem_rd_valid    = 1'b0;
    mem_rd_data     = '0;
    forever begin
      @(negedge clock);
      if (mem_wr && !mem_waitrequest) begin
        mem_lines[mem_addr] = mem_wr_data;
        last_wb_addr        = mem_addr;
        last_wb_data        = mem_wr_data;
        mem_wr_count++;
      end
      if (mem_rd && !mem_waitrequest) begin
        burst_line = mem_lines.exists(mem_addr) ? mem_lines[mem_addr] : rule_line(mem_addr);
        burst_word = 0;
        burst_left = NWORDS;
        mem_rd_count++;
      end
      if (mem_rd_valid) begin
        burst_word++;
        burst_left--;
      end
      stall     = (stall_run < MAX_STALL) && (take_bits(1) == 32'd1);
      gap       = (gap_run < MAX_STALL) && (take_bits(1) == 32'd1);
      stall_run = stall ? stall_run + 1 : 0;
      gap_run   = gap ? gap_run + 1 : 0;
      @(posedge clock);
      #1;
      mem_waitrequest = stall;
      mem_rd_valid    = (burst_left > 0) && !gap;
      if (burst_left > 0) begin
        mem_rd_data = burst_line[burst_word*DATA_WIDTH +: DATA_WIDTH];
      end
    end
  end

  // Returns just after the accepting edge
  task automatic wait_accept();
    do begin
      @(negedge clock);
    end while (cpu_waitrequest);
    @(posedge clock);
    #1;
  endtask

  // Response pulse is due in the cycle right after acceptance
  task automatic read_line(input addr_t addr, output line_t line);
    cpu_addr = addr;
    cpu_rd   = 1'b1;
    wait_accept();
    cpu_rd = 1'b0;
    @(negedge clock);
    check_flag("cpu_rd_valid", cpu_rd_valid, 1'b1);
    line = cpu_rd_line;
    @(negedge clock);
    check_flag("cpu_rd_valid", cpu_rd_valid, 1'b0);
    @(posedge clock);
    #1;
  endtask

  task automatic write_line(input addr_t addr, input line_t line);
    cpu_addr    = addr;
    cpu_wr      = 1'b1;
    cpu_wr_line = line;
    wait_accept();
    cpu_wr = 1'b0;
    ref_lines[line_base(addr)] = line;
  endtask

  task automatic read_and_check(input addr_t addr);
    line_t got;
    read_line(addr, got);
    check_line("cpu_rd_line", got, expected_line(addr));
  endtask

  task automatic cold_read_miss();
    int rd0;
    int wr0;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    read_and_check(ADDR_A);
    check_traffic(rd0, wr0, 1, 0);
  endtask

  task automatic repeated_read();
    int rd0;
    int wr0;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    read_and_check(ADDR_A);
    check_traffic(rd0, wr0, 0, 0);
  endtask

  task automatic write_then_read();
    int rd0;
    int wr0;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    write_line(ADDR_C, LINE_D);
    read_and_check(ADDR_C);
    check_traffic(rd0, wr0, 0, 0);
  endtask

  // Same index as the dirty line, different tag
  task automatic dirty_eviction();
    int rd0;
    int wr0;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    read_and_check(ADDR_E);
    check_traffic(rd0, wr0, 1, 1);
    check_addr("mem_addr", last_wb_addr, 32'h0000_2040);
    check_line("mem_wr_data", last_wb_data, LINE_D);
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    read_and_check(ADDR_C);
    check_traffic(rd0, wr0, 1, 0);
  endtask

  task automatic clean_conflict();
    int rd0;
    int wr0;
    rd0 = mem_rd_count;
    wr0 = mem_wr_count;
    read_and_check(ADDR_B);
    read_and_check(ADDR_A);
    check_traffic(rd0, wr0, 2, 0);
  endtask

  // Four tags per index keep conflicts frequent
  task automatic random_traffic();
    logic [31:0] tag_sel;
    logic [31:0] idx;
    logic [31:0] off;
    addr_t       addr;
    line_t       line;
    for (int n = 0; n < N_RANDOM; n++) begin
      tag_sel = take_bits(2);
      idx     = take_bits(INDEX_BITS);
      off     = take_bits(OFFSET_BITS);
      addr    = RANDOM_BASE | addr_t'(tag_sel << (OFFSET_BITS + INDEX_BITS)) |
                addr_t'(idx << OFFSET_BITS) | addr_t'(off);
      if (take_bits(1) == 32'd1) begin
        for (int w = 0; w < CLINE_WIDTH / 32; w++) begin
          line[w*32 +: 32] = take_bits(32);
        end
        write_line(addr, line);
      end else begin
        read_and_check(addr);
      end
    end
  endtask

  initial begin : run_tests
    cpu_addr    = '0;
    cpu_rd      = 1'b0;
    cpu_wr      = 1'b0;
    cpu_wr_line = '0;
    @(posedge reset_n);
    @(posedge clock);
    #1;
    cold_read_miss();
    repeated_read();
    write_then_read();
    dirty_eviction();
    clean_conflict();
    random_traffic();
    errors += int'(u_line_cache.u_cache_controller.u_line_cache_props.fail_count);
    $display("Checks: %0d, errors: %0d, memory reads: %0d, memory writes: %0d",
             checks, errors, mem_rd_count, mem_wr_count);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS * 1ns);
    $display("Timeout after %0d ns, a request never completed", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sim.f */
rtl/line_cache_pkg.sv
rtl/tag_store.sv
rtl/line_store.sv
rtl/cache_controller.sv
rtl/line_cache.sv
tests/clock_gen.sv
tests/line_cache_props.sv
tests/tb_line_cache.sv

/* Makefile */
TOP := tb_line_cache
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing log"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
